//--- design/wbt_cfg.svh
`ifndef WBT_CFG_SVH
`define WBT_CFG_SVH

// Wishbone bus widths.
`define WBT_ADR_W 12
`define WBT_DAT_W 32

// Threshold storage.
`define WBT_THRESH_W 18
`define WBT_NUM_ENTRIES 4
`define WBT_IDX_W 2

// Scaler period loaded at reset, in wb_clk cycles.
`define WBT_DEFAULT_PERIOD 100

`endif

//--- design/wbt_bus_pkg.sv
`include "wbt_cfg.svh"

package wbt_bus_pkg;

    // Decoded register targets.
    typedef enum logic [2:0] {
        sel_thresh,
        sel_ctrl,
        sel_status,
        sel_period,
        sel_none
    } reg_sel_e;

    // Address layout.
    localparam int ADR_REGION_BIT = 11;  // Clear for thresholds, set for control.
    localparam int ADR_BANK_BIT = 10;
    localparam int ADR_IDX_LSB = 2;
    localparam logic [`WBT_ADR_W-1:0] THRESH_ADR_MASK = 12'h40C;
    localparam logic [`WBT_ADR_W-1:0] CTRL_ADR_MASK = 12'h80C;

    // Word offsets in the control region.
    localparam logic [1:0] OFS_CTRL = 2'd0;
    localparam logic [1:0] OFS_STATUS = 2'd1;
    localparam logic [1:0] OFS_PERIOD = 2'd2;

    // Control write bits.
    localparam int CTRL_LOAD_BANK = 0;
    localparam int CTRL_LOAD = 1;
    localparam int CTRL_RESTART = 2;

endpackage

//--- design/wbt_thresh_pkg.sv
`include "wbt_cfg.svh"

package wbt_thresh_pkg;

    typedef logic [`WBT_THRESH_W-1:0] thresh_t;

    // Load sequencer states.
    typedef enum logic [1:0] {
        ld_idle,
        ld_stream,
        ld_update
    } load_state_e;

endpackage

//--- design/wb_reg_decode.sv
`timescale 1ns/1ps
`include "wbt_cfg.svh"

module wb_reg_decode (
    input  logic                     wb_clk,
    input  logic                     rst_n_i,
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  logic [`WBT_ADR_W-1:0]    wb_adr_i,
    input  logic [`WBT_DAT_W-1:0]    wb_dat_i,
    output logic                     wb_ack_o,
    output logic [`WBT_DAT_W-1:0]    wb_dat_o,
    output logic                     thr_we_o,
    output logic                     thr_bank_o,
    output logic [`WBT_IDX_W-1:0]    thr_idx_o,
    output wbt_thresh_pkg::thresh_t  thr_wdata_o,
    input  wbt_thresh_pkg::thresh_t  rd_thresh_i,
    output logic                     load_req_o,
    output logic                     load_bank_o,
    input  logic                     busy_i,
    input  logic                     refused_i,
    output logic                     status_rd_o,
    output logic                     period_we_o,
    output logic [`WBT_DAT_W-1:0]    period_wdata_o,
    output logic                     restart_o,
    input  logic [`WBT_DAT_W-1:0]    period_i
);
    import wbt_bus_pkg::*;

    reg_sel_e sel;
    logic     req;
    logic     wr;
    logic     rd;
    logic     ctrl_wr;

    // A new request is one not yet acknowledged.
    assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign wr = req && wb_we_i;
    assign rd = req && !wb_we_i;
    assign ctrl_wr = wr && (sel == sel_ctrl);

    always_comb begin
        sel = sel_none;
        if (!wb_adr_i[ADR_REGION_BIT]) begin
            if ((wb_adr_i & ~THRESH_ADR_MASK) == '0)
                sel = sel_thresh;
        end else if ((wb_adr_i & ~CTRL_ADR_MASK) == '0) begin
            case (wb_adr_i[ADR_IDX_LSB +: 2])
                OFS_CTRL:   sel = sel_ctrl;
                OFS_STATUS: sel = sel_status;
                OFS_PERIOD: sel = sel_period;
                default:    sel = sel_none;
            endcase
        end
    end

    // Threshold writes land on the edge that raises ack.
    assign thr_we_o = wr && (sel == sel_thresh);
    assign thr_bank_o = wb_adr_i[ADR_BANK_BIT];
    assign thr_idx_o = wb_adr_i[ADR_IDX_LSB +: `WBT_IDX_W];
    assign thr_wdata_o = wb_dat_i[`WBT_THRESH_W-1:0];
    assign status_rd_o = rd && (sel == sel_status);  // Clears the sticky refusal.

    always_ff @(posedge wb_clk) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
            load_req_o <= 1'b0;
            load_bank_o <= 1'b0;
            restart_o <= 1'b0;
            period_we_o <= 1'b0;
        end else begin
            wb_ack_o <= req;
            load_req_o <= ctrl_wr && wb_dat_i[CTRL_LOAD];  // High with ack.
            restart_o <= ctrl_wr && wb_dat_i[CTRL_RESTART];
            period_we_o <= wr && (sel == sel_period);
            if (ctrl_wr)
                load_bank_o <= wb_dat_i[CTRL_LOAD_BANK];
        end
    end

    always_ff @(posedge wb_clk) begin
        if (wr && (sel == sel_period))
            period_wdata_o <= wb_dat_i;
        if (rd) begin
            case (sel)
                sel_thresh: wb_dat_o <= {{(`WBT_DAT_W-`WBT_THRESH_W){1'b0}}, rd_thresh_i};
                sel_ctrl:   wb_dat_o <= {{(`WBT_DAT_W-1){1'b0}}, load_bank_o};
                sel_status: wb_dat_o <= {{(`WBT_DAT_W-2){1'b0}}, refused_i, busy_i};
                sel_period: wb_dat_o <= period_i;
                default:    wb_dat_o <= '0;  // Unmapped.
            endcase
        end
    end

    a_ack_single: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
        wb_ack_o |=> !wb_ack_o);

endmodule

//--- design/threshold_bank.sv
`timescale 1ns/1ps
`include "wbt_cfg.svh"

module threshold_bank (
    input  logic                           wb_clk,
    input  logic                           rst_n_i,
    input  logic                           thr_we_i,
    input  logic                           thr_bank_i,
    input  logic [`WBT_IDX_W-1:0]          thr_idx_i,
    input  wbt_thresh_pkg::thresh_t        thr_wdata_i,
    output wbt_thresh_pkg::thresh_t        rd_thresh_o,
    input  logic                           load_req_i,
    input  logic                           load_bank_i,
    input  logic                           scal_bank_i,
    input  logic                           status_rd_i,
    output logic                           busy_o,
    output logic                           refused_o,
    output wbt_thresh_pkg::thresh_t [1:0]  thresh_o,
    output logic [1:0]                     thresh_wr_o,
    output logic [1:0]                     thresh_update_o
);
    import wbt_thresh_pkg::*;

    localparam logic [`WBT_IDX_W-1:0] last_idx = `WBT_IDX_W'(`WBT_NUM_ENTRIES - 1);

    thresh_t                thr_mem [2][`WBT_NUM_ENTRIES];
    load_state_e            state;
    logic [`WBT_IDX_W-1:0]  cnt;
    logic [`WBT_IDX_W-1:0]  next_idx;
    logic                   ld_bank;

    always_ff @(posedge wb_clk) begin
        if (!rst_n_i) begin
            for (int b = 0; b < 2; b++)
                for (int e = 0; e < `WBT_NUM_ENTRIES; e++)
                    thr_mem[b][e] <= '0;
        end else if (thr_we_i) begin
            thr_mem[thr_bank_i][thr_idx_i] <= thr_wdata_i;
        end
    end

    assign rd_thresh_o = thr_mem[thr_bank_i][thr_idx_i];
    assign busy_o = (state != ld_idle);
    assign next_idx = cnt + 1'b1;

    always_ff @(posedge wb_clk) begin
        if (!rst_n_i) begin
            state <= ld_idle;
            cnt <= '0;
            ld_bank <= 1'b0;
            refused_o <= 1'b0;
            thresh_o <= '0;
            thresh_wr_o <= '0;
            thresh_update_o <= '0;
        end else begin
            thresh_update_o <= '0;
            if (status_rd_i)
                refused_o <= 1'b0;
            // The bank in use by the scaler cannot be reloaded.
            if (load_req_i && (busy_o || load_bank_i == scal_bank_i))
                refused_o <= 1'b1;
            case (state)
                ld_idle: begin
                    if (load_req_i && load_bank_i != scal_bank_i) begin
                        state <= ld_stream;
                        ld_bank <= load_bank_i;
                        cnt <= '0;
                        thresh_wr_o[load_bank_i] <= 1'b1;
                        thresh_o[load_bank_i] <= thr_mem[load_bank_i][0];
                    end
                end
                ld_stream: begin
                    if (cnt == last_idx) begin
                        thresh_wr_o <= '0;
                        thresh_update_o[ld_bank] <= 1'b1;  // Commit the new set.
                        state <= ld_update;
                    end else begin
                        cnt <= next_idx;
                        thresh_o[ld_bank] <= thr_mem[ld_bank][next_idx];
                    end
                end
                ld_update: state <= ld_idle;
                default:   state <= ld_idle;
            endcase
        end
    end

    a_one_lane: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
        $onehot0(thresh_wr_o) && $onehot0(thresh_update_o));

endmodule

//--- design/scaler_timer.sv
`timescale 1ns/1ps
`include "wbt_cfg.svh"

module scaler_timer #(
    parameter int unsigned DEFAULT_COUNT = `WBT_DEFAULT_PERIOD
) (
    input  logic                   wb_clk,
    input  logic                   rst_n_i,
    input  logic                   period_we_i,
    input  logic [`WBT_DAT_W-1:0]  period_wdata_i,
    input  logic                   restart_i,
    output logic [`WBT_DAT_W-1:0]  period_o,
    output logic                   scal_timer_o,
    output logic                   scal_rst_o
);
    logic [`WBT_DAT_W-1:0] cnt;
    logic [`WBT_DAT_W-1:0] last_cnt;

    // A zero period runs as a period of one.
    assign last_cnt = (period_o == '0) ? '0 : period_o - 1'b1;

    always_ff @(posedge wb_clk) begin
        if (!rst_n_i) begin
            period_o <= `WBT_DAT_W'(DEFAULT_COUNT);
            cnt <= '0;
            scal_timer_o <= 1'b0;
            scal_rst_o <= 1'b0;
        end else if (period_we_i || restart_i) begin
            if (period_we_i)
                period_o <= period_wdata_i;
            cnt <= '0;
            scal_timer_o <= 1'b0;
            scal_rst_o <= 1'b1;  // One cycle after ack.
        end else begin
            scal_rst_o <= 1'b0;
            if (cnt >= last_cnt) begin
                cnt <= '0;
                scal_timer_o <= 1'b1;  // Wrap.
            end else begin
                cnt <= cnt + 1'b1;
                scal_timer_o <= 1'b0;
            end
        end
    end

    a_tick_not_rst: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
        !(scal_timer_o && scal_rst_o));

endmodule

//--- design/wb_thresholds.sv
`timescale 1ns/1ps
`include "wbt_cfg.svh"

module wb_thresholds #(
    parameter int unsigned DEFAULT_COUNT = `WBT_DEFAULT_PERIOD
) (
    input  logic                           wb_clk,
    input  logic                           rst_n_i,
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [`WBT_ADR_W-1:0]          wb_adr_i,
    input  logic [`WBT_DAT_W-1:0]          wb_dat_i,
    output logic                           wb_ack_o,
    output logic [`WBT_DAT_W-1:0]          wb_dat_o,
    input  logic                           scal_bank_i,
    output logic                           scal_timer_o,
    output logic                           scal_rst_o,
    output wbt_thresh_pkg::thresh_t [1:0]  thresh_o,
    output logic [1:0]                     thresh_wr_o,
    output logic [1:0]                     thresh_update_o
);
    import wbt_thresh_pkg::*;

    logic                   thr_we;
    logic                   thr_bank;
    logic [`WBT_IDX_W-1:0]  thr_idx;
    thresh_t                thr_wdata;
    thresh_t                rd_thresh;
    logic                   load_req;
    logic                   load_bank;
    logic                   busy;
    logic                   refused;
    logic                   status_rd;
    logic                   period_we;
    logic [`WBT_DAT_W-1:0]  period_wdata;
    logic                   restart;
    logic [`WBT_DAT_W-1:0]  period;

    wb_reg_decode u_wb_reg_decode (
        .wb_clk         (wb_clk),
        .rst_n_i        (rst_n_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_ack_o       (wb_ack_o),
        .wb_dat_o       (wb_dat_o),
        .thr_we_o       (thr_we),
        .thr_bank_o     (thr_bank),
        .thr_idx_o      (thr_idx),
        .thr_wdata_o    (thr_wdata),
        .rd_thresh_i    (rd_thresh),
        .load_req_o     (load_req),
        .load_bank_o    (load_bank),
        .busy_i         (busy),
        .refused_i      (refused),
        .status_rd_o    (status_rd),
        .period_we_o    (period_we),
        .period_wdata_o (period_wdata),
        .restart_o      (restart),
        .period_i       (period)
    );

    threshold_bank u_threshold_bank (
        .wb_clk          (wb_clk),
        .rst_n_i         (rst_n_i),
        .thr_we_i        (thr_we),
        .thr_bank_i      (thr_bank),
        .thr_idx_i       (thr_idx),
        .thr_wdata_i     (thr_wdata),
        .rd_thresh_o     (rd_thresh),
        .load_req_i      (load_req),
        .load_bank_i     (load_bank),
        .scal_bank_i     (scal_bank_i),
        .status_rd_i     (status_rd),
        .busy_o          (busy),
        .refused_o       (refused),
        .thresh_o        (thresh_o),
        .thresh_wr_o     (thresh_wr_o),
        .thresh_update_o (thresh_update_o)
    );

    scaler_timer #(
        .DEFAULT_COUNT (DEFAULT_COUNT)
    ) u_scaler_timer (
        .wb_clk         (wb_clk),
        .rst_n_i        (rst_n_i),
        .period_we_i    (period_we),
        .period_wdata_i (period_wdata),
        .restart_i      (restart),
        .period_o       (period),
        .scal_timer_o   (scal_timer_o),
        .scal_rst_o     (scal_rst_o)
    );

endmodule

//--- bench/wb_thresholds_tb.sv
`timescale 1ns/1ps
`include "wbt_cfg.svh"

module wb_thresholds_tb;
    import wbt_bus_pkg::*;
    import wbt_thresh_pkg::*;

    localparam logic [11:0] adr_ctrl = 12'h800;
    localparam logic [11:0] adr_status = 12'h804;
    localparam logic [11:0] adr_period = 12'h808;
    localparam int num_writes = 40;
    localparam int num_ops = 130;  // Bus accesses and waits over all tests.
    localparam int max_period = `WBT_DEFAULT_PERIOD;
    localparam int watchdog_cycles = num_ops * (max_period + 20);

    logic              wb_clk;
    logic              rst_n_i;
    logic              wb_cyc_i;
    logic              wb_stb_i;
    logic              wb_we_i;
    logic [11:0]       wb_adr_i;
    logic [31:0]       wb_dat_i;
    logic              wb_ack_o;
    logic [31:0]       wb_dat_o;
    logic              scal_bank_i;
    logic              scal_timer_o;
    logic              scal_rst_o;
    thresh_t [1:0]     thresh_o;
    logic [1:0]        thresh_wr_o;
    logic [1:0]        thresh_update_o;

    thresh_t           model [2][4];
    bit                model_refused = 1'b0;
    int                cycle = 0;
    int                rst_count = 0;
    int                upd_count [2] = '{0, 0};
    int                tick_cycles [$];
    logic [18:0]       wr_log [$];  // Bank in bit 18, lane value below.

    wb_thresholds u_wb_thresholds (
        .wb_clk          (wb_clk),
        .rst_n_i         (rst_n_i),
        .wb_cyc_i        (wb_cyc_i),
        .wb_stb_i        (wb_stb_i),
        .wb_we_i         (wb_we_i),
        .wb_adr_i        (wb_adr_i),
        .wb_dat_i        (wb_dat_i),
        .wb_ack_o        (wb_ack_o),
        .wb_dat_o        (wb_dat_o),
        .scal_bank_i     (scal_bank_i),
        .scal_timer_o    (scal_timer_o),
        .scal_rst_o      (scal_rst_o),
        .thresh_o        (thresh_o),
        .thresh_wr_o     (thresh_wr_o),
        .thresh_update_o (thresh_update_o)
    );

    always #50 wb_clk = ~wb_clk;

    // Downstream outputs are sampled mid-cycle.
    always @(negedge wb_clk) begin
        cycle++;
        for (int b = 0; b < 2; b++) begin
            if (thresh_wr_o[b] === 1'b1)
                wr_log.push_back({1'(b), thresh_o[b]});
            if (thresh_update_o[b] === 1'b1)
                upd_count[b]++;
        end
        if (scal_timer_o === 1'b1)
            tick_cycles.push_back(cycle);
        if (scal_rst_o === 1'b1)
            rst_count++;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected)
            abort_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge wb_clk);
        #1;
    endtask

    task automatic wb_access(input logic we, input logic [11:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        do begin
            wait_cycles(1);
            waited++;
            if (waited > 20)
                abort_run($sformatf("No Wishbone ack for address 0x%03h within 20 cycles", adr));
        end while (wb_ack_o !== 1'b1);
        rdata = wb_dat_o;  // Valid in the ack cycle.
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
    endtask

    task automatic wb_write(input logic [11:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic expect_read(input string name, input logic [11:0] adr,
                               input logic [31:0] expected);
        logic [31:0] data;
        wb_access(1'b0, adr, 32'h0, data);
        check(name, data, expected);
    endtask

    function automatic logic [11:0] thresh_adr(input logic bank, input logic [1:0] idx);
        return {1'b0, bank, 6'b0, idx, 2'b00};
    endfunction

    function automatic bit is_mapped(input logic [11:0] adr);
        if (!adr[11])
            return (adr & ~12'h40C) == 12'h000;
        return ((adr & ~12'h80C) == 12'h000) && (adr[3:2] != 2'd3);
    endfunction

    task automatic check_reset_state();
        check("wb_ack_o", 32'(wb_ack_o), 32'h0);
        check("thresh_wr_o", 32'(thresh_wr_o), 32'h0);
        check("thresh_update_o", 32'(thresh_update_o), 32'h0);
        check("scal_timer_o", 32'(scal_timer_o), 32'h0);
        check("scal_rst_o", 32'(scal_rst_o), 32'h0);
        check("thresh_o[0]", 32'(thresh_o[0]), 32'h0);
        check("thresh_o[1]", 32'(thresh_o[1]), 32'h0);
        for (int b = 0; b < 2; b++)
            for (int i = 0; i < 4; i++)
                expect_read($sformatf("wb_dat_o thresh[%0d][%0d]", b, i),
                            thresh_adr(1'(b), 2'(i)), 32'h0);
        expect_read("wb_dat_o period", adr_period, 32'(`WBT_DEFAULT_PERIOD));
        expect_read("wb_dat_o status", adr_status, 32'h0);
    endtask

    task automatic unmapped_access();
        logic [11:0] adr;
        do begin
            adr = 12'($urandom);
        end while (is_mapped(adr));
        wb_write(adr, $urandom);
        expect_read($sformatf("wb_dat_o unmapped 0x%03h", adr), adr, 32'h0);
    endtask

    task automatic random_thresholds();
        logic        bank;
        logic [1:0]  idx;
        logic [31:0] data;
        for (int n = 0; n < num_writes; n++) begin
            bank = 1'($urandom);
            idx = 2'($urandom);
            data = $urandom;
            wb_write(thresh_adr(bank, idx), data);
            model[bank][idx] = data[17:0];  // Upper bits are dropped.
            if (n % 8 == 7)
                unmapped_access();
        end
        for (int n = 0; n < num_writes; n++) begin
            bank = 1'($urandom);
            idx = 2'($urandom);
            expect_read($sformatf("wb_dat_o thresh[%0d][%0d]", bank, idx),
                        thresh_adr(bank, idx), 32'(model[bank][idx]));
        end
    endtask

    task automatic load_stream(input logic bank);
        int waited;
        scal_bank_i = !bank;
        wr_log.delete();
        upd_count = '{0, 0};
        wb_write(adr_ctrl, 32'(bank) | (32'd1 << CTRL_LOAD));
        waited = 0;
        while (upd_count[bank] == 0) begin
            wait_cycles(1);
            waited++;
            if (waited > 20)
                abort_run($sformatf("Load of bank %0d never pulsed thresh_update_o", bank));
        end
        wait_cycles(3);
        check("thresh_wr_o strobe count", 32'(wr_log.size()), 32'd4);
        for (int k = 0; k < 4; k++)
            check($sformatf("thresh_o[%0d] entry %0d", bank, k), 32'(wr_log[k]),
                  32'({bank, model[bank][k]}));
        check($sformatf("thresh_update_o[%0d] pulses", bank), 32'(upd_count[bank]), 32'd1);
        check($sformatf("thresh_update_o[%0d] pulses", !bank), 32'(upd_count[!bank]), 32'd0);
        check("thresh_o held", 32'(thresh_o[bank]), 32'(model[bank][3]));
        expect_read("wb_dat_o status", adr_status, 32'h0);
    endtask

    task automatic load_refusal(input logic bank);
        scal_bank_i = bank;
        wr_log.delete();
        upd_count = '{0, 0};
        wb_write(adr_ctrl, 32'(bank) | (32'd1 << CTRL_LOAD));
        model_refused = 1'b1;  // Bank is in use by the scaler.
        wait_cycles(10);
        check("thresh_wr_o strobe count", 32'(wr_log.size()), 32'd0);
        check("thresh_update_o pulses", 32'(upd_count[0] + upd_count[1]), 32'd0);
        expect_read("wb_dat_o status", adr_status, {30'b0, model_refused, 1'b0});
        model_refused = 1'b0;
        expect_read("wb_dat_o status", adr_status, {30'b0, model_refused, 1'b0});
    endtask

    task automatic scaler_period();
        int period;
        int rst_before;
        int waited;
        period = 3 + int'($urandom % 38);
        rst_before = rst_count;
        wb_write(adr_period, 32'(period));
        wait_cycles(3);
        check("scal_rst_o pulses after period write", 32'(rst_count - rst_before), 32'd1);
        expect_read("wb_dat_o period", adr_period, 32'(period));
        tick_cycles.delete();
        waited = 0;
        while (tick_cycles.size() < 6) begin
            wait_cycles(1);
            waited++;
            if (waited > 7 * (period + 2))
                abort_run("scal_timer_o stopped pulsing after the period write");
        end
        for (int k = 1; k < 6; k++)
            check("scal_timer_o gap", 32'(tick_cycles[k] - tick_cycles[k-1]), 32'(period));
        rst_before = rst_count;
        wb_write(adr_ctrl, 32'd1 << CTRL_RESTART);
        wait_cycles(3);
        check("scal_rst_o pulses after restart", 32'(rst_count - rst_before), 32'd1);
    endtask

    initial begin
        void'($urandom(49));
        wb_clk = 1'b0;
        rst_n_i = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        scal_bank_i = 1'b0;
        for (int b = 0; b < 2; b++)
            for (int i = 0; i < 4; i++)
                model[b][i] = '0;
        repeat (5) @(posedge wb_clk);
        #1;
        rst_n_i = 1'b1;
        check_reset_state();
        random_thresholds();
        load_stream(1'b0);
        load_stream(1'b1);
        load_refusal(1'b0);
        load_refusal(1'b1);
        scaler_period();
        $display("TEST PASSED");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge wb_clk);
        abort_run("Watchdog expired before the tests finished");
    end

endmodule

//--- compile.f
+incdir+design
design/wbt_bus_pkg.sv
design/wbt_thresh_pkg.sv
design/wb_reg_decode.sv
design/threshold_bank.sv
design/scaler_timer.sv
design/wb_thresholds.sv
bench/wb_thresholds_tb.sv

//--- Makefile
TOP = wb_thresholds_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then \
		echo "Simulation failed, see sim.log"; \
		exit 1; \
	fi
	@if ! grep -q "TEST PASSED" sim.log; then \
		echo "Simulation ended without a result, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
